// File: Makefile
TOP := xt_peripherals_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f xt_peripherals.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f xt_peripherals.f

clean:
	rm -rf obj_dir sim.log

// File: test/tb_bus_tasks.svh
/*
 * Bus cycle tasks for the XT peripheral testbench
 * I/O and memory cycles with bounded waits, and a model of the EMS registers
 */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam int WAIT_LIMIT = 8;

// EMS page register model
logic [6:0] model_page [4];
logic       model_enabled [4];

task automatic model_reset();
    for (int k = 0; k < 4; k++) begin
        model_page[k] = 7'h00;
        model_enabled[k] = 1'b0;
    end
endtask

task automatic model_write(input logic [1:0] slot, input logic [7:0] value);
    if (value == 8'hFF) begin
        model_page[slot] = 7'h7F;
        model_enabled[slot] = 1'b0;
    end
    else if (value < 8'h80) begin
        model_page[slot] = value[6:0];
        model_enabled[slot] = 1'b1;
    end
endtask

function automatic logic [7:0] model_read(input logic [1:0] slot);
    if (model_enabled[slot]) begin
        return {1'b0, model_page[slot]};
    end
    return 8'hFF;
endfunction

// Returns at a falling edge once the chipset no longer drives the bus
task automatic wait_bus_idle();
    int count;
    count = 0;
    @(negedge clock);
    while (data_bus_out_from_chipset && count < WAIT_LIMIT) begin
        @(negedge clock);
        count++;
    end
    if (data_bus_out_from_chipset) begin
        abort_run("Timeout waiting for the chipset to release the data bus");
    end
endtask

task automatic io_write(input xt_io_pkg::addr_t addr, input xt_io_pkg::data_t value);
    wait_bus_idle();
    @(posedge clock);
    address <= addr;
    data <= value;
    io_write_n <= 1'b0;
    address_enable_n <= 1'b0;
    @(posedge clock);
    io_write_n <= 1'b1;
    address_enable_n <= 1'b1;
endtask

// Response is checked one cycle after the strobe is sampled
task automatic io_read(input xt_io_pkg::addr_t addr, input xt_io_pkg::data_t exp_data,
                       input logic exp_flag, input string name);
    int count;
    wait_bus_idle();
    @(posedge clock);
    address <= addr;
    io_read_n <= 1'b0;
    address_enable_n <= 1'b0;
    @(posedge clock);
    io_read_n <= 1'b1;
    address_enable_n <= 1'b1;
    bus_check <= 1'b1;
    expected_data <= exp_data;
    expected_flag <= exp_flag;
    test_name <= name;
    count = 0;
    @(negedge clock);
    while (data_bus_out_from_chipset !== exp_flag && count < WAIT_LIMIT) begin
        @(negedge clock);
        count++;
    end
    if (data_bus_out_from_chipset !== exp_flag) begin
        abort_run("Timeout waiting for the read response");
    end
    @(posedge clock);
    bus_check <= 1'b0;
endtask

task automatic decode_cycle(input xt_io_pkg::addr_t addr, input logic write,
                            input logic aen_n, input logic [7:0] exp_select,
                            input string name);
    wait_bus_idle();
    @(posedge clock);
    address <= addr;
    io_read_n <= write;
    io_write_n <= ~write;
    address_enable_n <= aen_n;
    select_check <= 1'b1;
    expected_select <= exp_select;
    test_name <= name;
    @(posedge clock);
    io_read_n <= 1'b1;
    io_write_n <= 1'b1;
    address_enable_n <= 1'b1;
    select_check <= 1'b0;
endtask

// Memory read, or an I/O read at the same address when io_strobe is set
task automatic memory_cycle(input xt_io_pkg::addr_t addr, input logic io_strobe,
                            input logic [3:0] exp_hits, input string name);
    wait_bus_idle();
    @(posedge clock);
    address <= addr;
    memory_read_n <= io_strobe;
    io_read_n <= ~io_strobe;
    address_enable_n <= 1'b0;
    hit_check <= 1'b1;
    expected_hits <= exp_hits;
    test_name <= name;
    @(posedge clock);
    memory_read_n <= 1'b1;
    io_read_n <= 1'b1;
    address_enable_n <= 1'b1;
    hit_check <= 1'b0;
endtask

`endif

// File: test/xt_peripherals_tb.sv
/*
 * Testbench for the XT peripheral I/O glue
 * Port decoding, EMS mapper, window hits and printer latch
 */
`timescale 1ns/1ps

module xt_peripherals_tb;

    logic                  clock = 1'b0;
    logic                  reset;
    xt_io_pkg::addr_t      address;
    xt_io_pkg::data_t      data;
    logic                  io_read_n;
    logic                  io_write_n;
    logic                  memory_read_n;
    logic                  address_enable_n;
    logic                  ems_enabled;
    xt_io_pkg::ems_frame_t ems_frame;
    logic [7:0]            io_block_select_n;
    logic [3:0]            ems_window_hit;
    xt_io_pkg::data_t      data_bus_out;
    logic                  data_bus_out_from_chipset;

    // Expected values, valid while the matching check flag is set
    logic       bus_check = 1'b0;
    logic       select_check = 1'b0;
    logic       hit_check = 1'b0;
    logic [7:0] expected_data = 8'h00;
    logic       expected_flag = 1'b0;
    logic [7:0] expected_select = 8'hFF;
    logic [3:0] expected_hits = 4'h0;
    string      test_name = "idle";
    integer     seed = 32'h1e62;

    always #10 clock = ~clock;

    xt_peripherals dut (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .memory_read_n_i             (memory_read_n),
        .address_enable_n_i          (address_enable_n),
        .ems_enabled_i               (ems_enabled),
        .ems_frame_i                 (ems_frame),
        .io_block_select_n_o         (io_block_select_n),
        .ems_window_hit_o            (ems_window_hit),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "tb_bus_tasks.svh"

    // Checked at the falling edge, away from the driving edge
    bus_data_check: assert property (@(negedge clock) disable iff (reset)
        bus_check |-> data_bus_out == expected_data)
        else abort_run($sformatf("Fail %s expected %h actual %h",
                                 test_name, expected_data, data_bus_out));

    bus_flag_check: assert property (@(negedge clock) disable iff (reset)
        bus_check |-> data_bus_out_from_chipset == expected_flag)
        else abort_run($sformatf("Fail %s expected %b actual %b",
                                 test_name, expected_flag, data_bus_out_from_chipset));

    block_select_check: assert property (@(negedge clock) disable iff (reset)
        select_check |-> io_block_select_n == expected_select)
        else abort_run($sformatf("Fail %s expected %b actual %b",
                                 test_name, expected_select, io_block_select_n));

    window_hit_check: assert property (@(negedge clock) disable iff (reset)
        hit_check |-> ems_window_hit == expected_hits)
        else abort_run($sformatf("Fail %s expected %b actual %b",
                                 test_name, expected_hits, ems_window_hit));

    initial begin
        logic [31:0] r;
        logic [1:0]  slot;
        logic [7:0]  value;
        logic [3:0]  nibble;
        logic [3:0]  hits;
        reset = 1'b1;
        address = '0;
        data = '0;
        io_read_n = 1'b1;
        io_write_n = 1'b1;
        memory_read_n = 1'b1;
        address_enable_n = 1'b1;
        ems_enabled = 1'b1;
        ems_frame = 2'd0;
        model_reset();
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // Reset state
        @(posedge clock);
        bus_check <= 1'b1;
        select_check <= 1'b1;
        test_name <= "reset_state";
        @(posedge clock);
        bus_check <= 1'b0;
        select_check <= 1'b0;
        io_read(20'h00378, 8'hFF, 1'b1, "reset_lpt");
        for (int k = 0; k < 4; k++) begin
            io_read({18'h00098, k[1:0]}, 8'hFF, 1'b1, "reset_ems");
        end

        // Block decoding
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            decode_cycle({12'h000, r[7:0]}, r[8], 1'b0, ~(8'h01 << r[7:5]), "block_decode");
            r = $random(seed);
            value = r[7:0];
            decode_cycle({10'h000, (r[9:8] == 2'b00) ? 2'b01 : r[9:8], value}, 1'b0, 1'b0,
                         8'hFF, "upper_ports");
            decode_cycle({12'h000, r[17:10]}, r[18], 1'b1, 8'hFF, "no_address_enable");
        end

        // EMS register rules
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            slot = r[1:0];
            case (r[3:2])
                2'd0:    value = 8'hFF;
                2'd3:    value = {1'b1, r[10:4]};
                default: value = {1'b0, r[10:4]};
            endcase
            io_write({18'h00098, slot}, value);
            model_write(slot, value);
            r = $random(seed);
            io_read({18'h00098, r[1:0]}, model_read(r[1:0]), 1'b1, "ems_register");
        end

        // EMS switched off ignores writes and reads
        @(posedge clock);
        ems_enabled <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            io_write({18'h00098, k[1:0]}, {1'b0, r[6:0]});
        end
        io_read(20'h00261, 8'h00, 1'b0, "ems_disabled_read");
        @(posedge clock);
        ems_enabled <= 1'b1;
        for (int k = 0; k < 4; k++) begin
            io_read({18'h00098, k[1:0]}, model_read(k[1:0]), 1'b1, "ems_disabled_write");
        end

        // Window hits, every other slot enabled, then the opposite set
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 4; k++) begin
                value = (k[0] == p[0]) ? {6'h04, k[1:0]} : 8'hFF;
                io_write({18'h00098, k[1:0]}, value);
                model_write(k[1:0], value);
            end
            for (int f = 0; f < 4; f++) begin
                @(posedge clock);
                ems_frame <= f[1:0];
                nibble = (f == 0) ? 4'hA : (f == 1) ? 4'hC : 4'hD;
                for (int k = 0; k < 4; k++) begin
                    r = $random(seed);
                    hits = model_enabled[k] ? (4'b0001 << k) : 4'b0000;
                    memory_cycle({nibble, k[1:0], r[13:0]}, 1'b0, hits, "window_hit");
                    memory_cycle({nibble, k[1:0], r[13:0]}, 1'b1, 4'b0000, "io_suppress");
                end
            end
        end

        // Printer data latch
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            io_write(20'h00378, r[7:0]);
            io_read(20'h00378, r[7:0], 1'b1, "lpt_latch");
        end
        io_read(20'h00300, 8'h00, 1'b0, "unmapped_read");

        $display("Everything OK");
        $finish;
    end

endmodule

// File: verilog/bus_readback.sv
/*
 * Chipset read-back path
 * Keeps the printer data latch and registers the byte the chipset
 * drives onto the CPU data bus, with its driven flag
 */
`timescale 1ns/1ps

module bus_readback (
    input  logic                                            clock,
    input  logic                                            reset,
    input  xt_io_pkg::addr_t                                address_i,
    input  xt_io_pkg::data_t                                data_i,
    input  logic                                            io_read_n_i,
    input  logic                                            io_write_n_i,
    input  logic                                            ems_port_hit_i,
    input  logic                                            lpt_port_hit_i,
    input  xt_io_pkg::ems_page_t [xt_io_pkg::EMS_SLOTS-1:0] slot_page_i,
    input  logic [xt_io_pkg::EMS_SLOTS-1:0]                 slot_enabled_i,
    output xt_io_pkg::data_t                                data_bus_out_o,
    output logic                                            data_bus_out_from_chipset_o
);

    // Printer data latch
    xt_io_pkg::data_t lpt_data;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= xt_io_pkg::LPT_RESET_DATA;
        end
        else if (lpt_port_hit_i && !io_write_n_i) begin
            lpt_data <= data_i;
        end
    end

    // EMS slot addressed by the current port
    xt_io_pkg::ems_slot_t read_slot;
    xt_io_pkg::data_t     ems_read_data;

    assign read_slot = address_i[1:0];

    always_comb begin
        if (slot_enabled_i[read_slot]) begin
            ems_read_data = {1'b0, slot_page_i[read_slot]};
        end
        else begin
            ems_read_data = xt_io_pkg::EMS_EMPTY_READ;
        end
    end

    // One cycle behind the sampled read
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= '0;
        end
        else if (ems_port_hit_i && !io_read_n_i) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= ems_read_data;
        end
        else if (lpt_port_hit_i && !io_read_n_i) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= lpt_data;
        end
        else begin
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= '0;
        end
    end

endmodule

// File: verilog/ems_mapper.sv
/*
 * EMS page mapper
 * Four page registers written through the I/O window, with a staged
 * write pipeline, and the memory window hits of the chosen page frame
 */
`timescale 1ns/1ps

module ems_mapper (
    input  logic                                            clock,
    input  logic                                            reset,
    input  xt_io_pkg::addr_t                                address_i,
    input  xt_io_pkg::data_t                                data_i,
    input  logic                                            io_write_n_i,
    input  logic                                            io_read_n_i,
    input  logic                                            ems_port_hit_i,
    input  xt_io_pkg::ems_frame_t                           ems_frame_i,
    output xt_io_pkg::ems_page_t [xt_io_pkg::EMS_SLOTS-1:0] slot_page_o,
    output logic [xt_io_pkg::EMS_SLOTS-1:0]                 slot_enabled_o,
    output logic [xt_io_pkg::EMS_SLOTS-1:0]                 ems_window_hit_o
);

    // Write decode
    logic write_strobe;
    logic write_disable;
    logic write_enable;

    assign write_strobe  = ems_port_hit_i & ~io_write_n_i;
    assign write_disable = (data_i == xt_io_pkg::EMS_DISABLE_CODE);
    assign write_enable  = (data_i < xt_io_pkg::EMS_ENABLE_LIMIT);

    // Stage 1 control
    logic stage_valid;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end
        else begin
            // Values between 80h and FEh never reach the commit stage
            stage_valid <= write_strobe & (write_disable | write_enable);
        end
    end

    // Stage 1 payload
    xt_io_pkg::ems_slot_t stage_slot;
    xt_io_pkg::ems_page_t stage_page;
    logic                 stage_enable;

    always_ff @(posedge clock) begin
        stage_slot   <= address_i[1:0];
        stage_enable <= write_enable;
        // FFh leaves 7Fh in the low bits, the page of a disabled slot
        stage_page   <= data_i[6:0];
    end

    // Stage 2, the page registers themselves
    xt_io_pkg::ems_page_t [xt_io_pkg::EMS_SLOTS-1:0] slot_page_q;
    logic [xt_io_pkg::EMS_SLOTS-1:0]                 slot_enabled_q;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            slot_page_q    <= '0;
            slot_enabled_q <= '0;
        end
        else if (stage_valid) begin
            slot_page_q[stage_slot]    <= stage_page;
            slot_enabled_q[stage_slot] <= stage_enable;
        end
    end

    assign slot_page_o    = slot_page_q;
    assign slot_enabled_o = slot_enabled_q;

    // Page frame segment
    logic [3:0] frame_nibble;

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_nibble = xt_io_pkg::FRAME_A_NIBBLE;
            2'd1:    frame_nibble = xt_io_pkg::FRAME_C_NIBBLE;
            default: frame_nibble = xt_io_pkg::FRAME_D_NIBBLE;
        endcase
    end

    // Each slot covers 16 KB of the 64 KB frame
    logic io_strobe;

    assign io_strobe = ~io_read_n_i | ~io_write_n_i;

    always_comb begin
        for (int k = 0; k < xt_io_pkg::EMS_SLOTS; k++) begin
            ems_window_hit_o[k] = ~io_strobe & slot_enabled_q[k] &
                (address_i[19:14] == {frame_nibble, xt_io_pkg::ems_slot_t'(k)});
        end
    end

endmodule

// File: verilog/io_port_decoder.sv
/*
 * I/O port decoder
 * Turns the CPU address and strobes into 32-byte block selects
 * and the EMS and printer port hits
 */
`timescale 1ns/1ps

module io_port_decoder #(
    parameter logic [15:0] ems_port_base = 16'h0260,
    parameter logic [15:0] lpt_port_base = 16'h0378
) (
    input  xt_io_pkg::addr_t                   address_i,
    input  logic                               io_read_n_i,
    input  logic                               io_write_n_i,
    input  logic                               address_enable_n_i,
    input  logic                               ems_enabled_i,
    output logic [xt_io_pkg::IO_BLOCKS-1:0]    io_block_select_n_o,
    output logic                               ems_port_hit_o,
    output logic                               lpt_port_hit_o
);

    logic       cycle_valid;
    logic       io_strobe;
    logic       io_cycle;
    logic       low_page;
    logic [2:0] block_index;

    assign cycle_valid = ~address_enable_n_i;
    assign io_strobe   = ~io_read_n_i | ~io_write_n_i;
    assign io_cycle    = cycle_valid & io_strobe;

    // Only ports 000h-0FFh are split into blocks
    assign low_page    = (address_i[9:8] == 2'b00);
    assign block_index = address_i[7:5];

    always_comb begin
        io_block_select_n_o = '1;
        if (io_cycle && low_page) begin
            case (block_index)
                3'd0:    io_block_select_n_o = 8'b1111_1110;
                3'd1:    io_block_select_n_o = 8'b1111_1101;
                3'd2:    io_block_select_n_o = 8'b1111_1011;
                3'd3:    io_block_select_n_o = 8'b1111_0111;
                3'd4:    io_block_select_n_o = 8'b1110_1111;
                3'd5:    io_block_select_n_o = 8'b1101_1111;
                3'd6:    io_block_select_n_o = 8'b1011_1111;
                3'd7:    io_block_select_n_o = 8'b0111_1111;
                default: io_block_select_n_o = '1;
            endcase
        end
    end

    // EMS page registers sit in a window of four ports
    logic ems_window_match;

    assign ems_window_match = (address_i[15:2] == ems_port_base[15:2]);
    assign ems_port_hit_o   = io_cycle & ems_enabled_i & ems_window_match;

    // Printer data port only, the status and control ports are not decoded
    logic lpt_data_match;

    assign lpt_data_match = (address_i[15:0] == lpt_port_base);
    assign lpt_port_hit_o = io_cycle & lpt_data_match;

endmodule

// File: verilog/xt_io_pkg.sv
/*
 * XT peripheral I/O glue shared definitions
 * Bus widths, EMS mapper types and port decoding constants
 */
package xt_io_pkg;

    // Bus
    typedef logic [19:0] addr_t;
    typedef logic [7:0]  data_t;

    // EMS mapper
    typedef logic [1:0] ems_slot_t;
    typedef logic [6:0] ems_page_t;
    typedef logic [1:0] ems_frame_t;

    localparam int EMS_SLOTS = 4;
    localparam int IO_BLOCKS = 8;

    // Page register write values
    localparam data_t EMS_DISABLE_CODE = 8'hFF;
    localparam data_t EMS_ENABLE_LIMIT = 8'h80;

    // Read-back of a slot that is switched off
    localparam data_t EMS_EMPTY_READ = 8'hFF;

    // Upper address nibble of each page frame
    localparam logic [3:0] FRAME_A_NIBBLE = 4'hA;
    localparam logic [3:0] FRAME_C_NIBBLE = 4'hC;
    localparam logic [3:0] FRAME_D_NIBBLE = 4'hD;

    // Printer data latch
    localparam data_t LPT_RESET_DATA = 8'hFF;

endpackage

// File: verilog/xt_peripherals.sv
/*
 * XT peripheral I/O glue, top level
 * Port decoder, EMS page mapper and chipset read-back path
 */
`timescale 1ns/1ps

module xt_peripherals #(
    parameter logic [15:0] ems_port_base = 16'h0260,
    parameter logic [15:0] lpt_port_base = 16'h0378
) (
    input  logic                               clock,
    input  logic                               reset,
    input  xt_io_pkg::addr_t                   address_i,
    input  xt_io_pkg::data_t                   data_i,
    input  logic                               io_read_n_i,
    input  logic                               io_write_n_i,
    // Part of the bus, nothing here answers memory reads
    input  logic                               memory_read_n_i,
    input  logic                               address_enable_n_i,
    input  logic                               ems_enabled_i,
    input  xt_io_pkg::ems_frame_t              ems_frame_i,
    output logic [xt_io_pkg::IO_BLOCKS-1:0]    io_block_select_n_o,
    output logic [xt_io_pkg::EMS_SLOTS-1:0]    ems_window_hit_o,
    output xt_io_pkg::data_t                   data_bus_out_o,
    output logic                               data_bus_out_from_chipset_o
);

    logic                                            ems_port_hit;
    logic                                            lpt_port_hit;
    xt_io_pkg::ems_page_t [xt_io_pkg::EMS_SLOTS-1:0] slot_page;
    logic [xt_io_pkg::EMS_SLOTS-1:0]                 slot_enabled;

    io_port_decoder #(
        .ems_port_base          (ems_port_base),
        .lpt_port_base          (lpt_port_base)
    ) u_io_port_decoder (
        .address_i              (address_i),
        .io_read_n_i            (io_read_n_i),
        .io_write_n_i           (io_write_n_i),
        .address_enable_n_i     (address_enable_n_i),
        .ems_enabled_i          (ems_enabled_i),
        .io_block_select_n_o    (io_block_select_n_o),
        .ems_port_hit_o         (ems_port_hit),
        .lpt_port_hit_o         (lpt_port_hit)
    );

    ems_mapper u_ems_mapper (
        .clock                  (clock),
        .reset                  (reset),
        .address_i              (address_i),
        .data_i                 (data_i),
        .io_write_n_i           (io_write_n_i),
        .io_read_n_i            (io_read_n_i),
        .ems_port_hit_i         (ems_port_hit),
        .ems_frame_i            (ems_frame_i),
        .slot_page_o            (slot_page),
        .slot_enabled_o         (slot_enabled),
        .ems_window_hit_o       (ems_window_hit_o)
    );

    bus_readback u_bus_readback (
        .clock                          (clock),
        .reset                          (reset),
        .address_i                      (address_i),
        .data_i                         (data_i),
        .io_read_n_i                    (io_read_n_i),
        .io_write_n_i                   (io_write_n_i),
        .ems_port_hit_i                 (ems_port_hit),
        .lpt_port_hit_i                 (lpt_port_hit),
        .slot_page_i                    (slot_page),
        .slot_enabled_i                 (slot_enabled),
        .data_bus_out_o                 (data_bus_out_o),
        .data_bus_out_from_chipset_o    (data_bus_out_from_chipset_o)
    );

endmodule

// File: xt_peripherals.f
+incdir+test
verilog/xt_io_pkg.sv
verilog/io_port_decoder.sv
verilog/ems_mapper.sv
verilog/bus_readback.sv
verilog/xt_peripherals.sv
test/xt_peripherals_tb.sv
